// ==== all.f ====
+incdir+include
rtl/mem_pkg.sv
rtl/req_slot.sv
rtl/bus_arbiter_fsm.sv
rtl/sram_wait_timer.sv
rtl/sram_store.sv
rtl/mmio_regs.sv
rtl/mem_subsys_top.sv
verification/mem_subsys_tb.sv

// ==== verification/mem_subsys_tb.sv ====
`include "mem_cfg_cfg.svh"

module mem_subsys_tb import mem_pkg::*;;

    localparam int depth     = 2 ** `MEM_DEPTH_LOG2;
    localparam int num_regs  = 2 ** `DEV_REGS_LOG2;
    // top index bit splits the sram between the two ports in random phases
    localparam int half_bit  = $clog2(`MEM_STRB_W) + `MEM_DEPTH_LOG2 - 1;
    localparam int n_rand    = 150;
    localparam int n_dir     = 200;
    localparam int total_req = n_dir + 4 * n_rand;
    localparam int timeout   = total_req * (`SRAM_WAIT + 8) * 4 + 1000;

    logic       clk = 1'b0;
    logic       rst_i;
    logic       fetch_req_valid_i;
    logic       fetch_req_ready_o;
    fetch_req_t fetch_req_i;
    logic       fetch_rsp_valid_o;
    logic       fetch_rsp_ready_i;
    mem_rsp_t   fetch_rsp_o;
    logic       data_req_valid_i;
    logic       data_req_ready_o;
    data_req_t  data_req_i;
    logic       data_rsp_valid_o;
    logic       data_rsp_ready_i;
    mem_rsp_t   data_rsp_o;

    // reference model state
    data_t    sram_shadow [depth];
    strb_t    sram_known  [depth];
    data_t    dev_shadow  [num_regs];
    mem_rsp_t fetch_exp_q [$];
    bit       fetch_chk_q [$];
    mem_rsp_t data_exp_q  [$];
    bit       data_chk_q  [$];

    int mismatch_errs = 0;
    int other_errs    = 0;
    int stall_cnt     = 0;
    int rdy_pct       = 100;

    mem_subsys_top i_mem_subsys_top (.*);

    always #2 clk = !clk;

    //************************************************************
    // reference model
    //************************************************************
    function automatic bit in_window(input addr_t a);
        return (a >= `MEM_BASE) && (a <= `MEM_LIMIT);
    endfunction

    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w,
                                          input strb_t strb);
        data_t res;
        res = old_w;
        for (int b = 0; b < `MEM_STRB_W; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic model_data(input data_req_t req);
        mem_rsp_t exp;
        bit       chk;
        int       idx;
        exp.rdata = '0;
        exp.resp  = resp_okay;
        chk       = 1'b1;
        if (in_window(req.addr)) begin
            idx = (req.addr / `MEM_STRB_W) % depth;
            if (req.we) begin
                sram_shadow[idx] = merge_bytes(sram_shadow[idx], req.wdata, req.strb);
                sram_known[idx]  = sram_known[idx] | req.strb;
            end else begin
                exp.rdata = sram_shadow[idx];
                chk       = (sram_known[idx] == '1);
            end
        end else begin
            idx = (req.addr / `MEM_STRB_W) % num_regs;
            if (req.we) begin
                dev_shadow[idx] = merge_bytes(dev_shadow[idx], req.wdata, req.strb);
            end else begin
                exp.rdata = dev_shadow[idx];
            end
        end
        data_exp_q.push_back(exp);
        data_chk_q.push_back(chk);
    endtask

    task automatic model_fetch(input fetch_req_t req);
        mem_rsp_t exp;
        bit       chk;
        int       idx;
        exp.rdata = '0;
        exp.resp  = resp_decerr;
        chk       = 1'b1;
        if (in_window(req.addr)) begin
            idx       = (req.addr / `MEM_STRB_W) % depth;
            exp.rdata = sram_shadow[idx];
            exp.resp  = resp_okay;
            chk       = (sram_known[idx] == '1);
        end
        fetch_exp_q.push_back(exp);
        fetch_chk_q.push_back(chk);
    endtask

    //************************************************************
    // response checks
    //************************************************************
    task automatic check_fetch_rsp(input mem_rsp_t got, input mem_rsp_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("Mismatch at %0t: fetch response data %h resp %b, expected %h resp %b",
                     $time, got.rdata, got.resp, exp.rdata, exp.resp);
        end
    endtask

    task automatic check_data_rsp(input mem_rsp_t got, input mem_rsp_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("Mismatch at %0t: data response data %h resp %b, expected %h resp %b",
                     $time, got.rdata, got.resp, exp.rdata, exp.resp);
        end
    endtask

    // response checker and request stall count
    always @(negedge clk) begin
        if (fetch_rsp_valid_o && fetch_rsp_ready_i) begin
            if (fetch_exp_q.size() == 0) begin
                other_errs++;
                $display("error at %0t: fetch response with no request outstanding", $time);
            end else if (fetch_chk_q.pop_front()) begin
                check_fetch_rsp(fetch_rsp_o, fetch_exp_q.pop_front());
            end else begin
                void'(fetch_exp_q.pop_front());
            end
        end
        if (data_rsp_valid_o && data_rsp_ready_i) begin
            if (data_exp_q.size() == 0) begin
                other_errs++;
                $display("error at %0t: data response with no request outstanding", $time);
            end else if (data_chk_q.pop_front()) begin
                check_data_rsp(data_rsp_o, data_exp_q.pop_front());
            end else begin
                void'(data_exp_q.pop_front());
            end
        end
        if ((data_req_valid_i && !data_req_ready_o) ||
            (fetch_req_valid_i && !fetch_req_ready_o)) begin
            stall_cnt++;
        end
    end

    //************************************************************
    // stimulus
    //************************************************************
    always @(posedge clk) begin
        #1;
        fetch_rsp_ready_i = ($urandom_range(99) < rdy_pct);
        data_rsp_ready_i  = ($urandom_range(99) < rdy_pct);
    end

    task automatic send_data(input addr_t addr, input logic we, input data_t wdata,
                             input strb_t strb);
        bit hs;
        hs                     = 1'b0;
        data_req_valid_i       = 1'b1;
        data_req_i.addr        = addr;
        data_req_i.we          = we;
        data_req_i.wdata       = wdata;
        data_req_i.strb        = strb;
        while (!hs) begin
            @(negedge clk);
            hs = data_req_ready_o;
            if (hs) begin
                model_data(data_req_i);
            end
            @(posedge clk);
            #1;
        end
        data_req_valid_i = 1'b0;
    endtask

    task automatic send_fetch(input addr_t addr);
        bit hs;
        hs                = 1'b0;
        fetch_req_valid_i = 1'b1;
        fetch_req_i.addr  = addr;
        while (!hs) begin
            @(negedge clk);
            hs = fetch_req_ready_o;
            if (hs) begin
                model_fetch(fetch_req_i);
            end
            @(posedge clk);
            #1;
        end
        fetch_req_valid_i = 1'b0;
    endtask

    function automatic addr_t rand_in_window(input bit upper_half);
        addr_t a;
        a           = `MEM_BASE + ($urandom % (`MEM_LIMIT - `MEM_BASE));
        a[half_bit] = upper_half;
        return a;
    endfunction

    function automatic addr_t rand_outside();
        if ($urandom_range(1)) begin
            return $urandom % `MEM_BASE;
        end
        return `MEM_LIMIT + 1 + ($urandom % (32'hffff_ffff - `MEM_LIMIT));
    endfunction

    task automatic idle_gap();
        repeat ($urandom_range(2)) begin
            @(posedge clk);
            #1;
        end
    endtask

    // data port stays in the lower sram half so fetch reads never race it
    task automatic run_data_traffic(input int n);
        addr_t a;
        for (int i = 0; i < n; i++) begin
            a = $urandom_range(1) ? rand_in_window(1'b0) : rand_outside();
            send_data(a, logic'($urandom_range(1)), {$urandom, $urandom}, strb_t'($urandom));
            idle_gap();
        end
    endtask

    task automatic run_fetch_traffic(input int n);
        addr_t a;
        for (int i = 0; i < n; i++) begin
            a = ($urandom_range(9) < 7) ? rand_in_window(1'b1) : rand_outside();
            send_fetch(a);
            idle_gap();
        end
    endtask

    task automatic wait_drained();
        while (fetch_exp_q.size() != 0 || data_exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    initial begin
        #(timeout);
        $display("timeout: responses still outstanding after %0d time units", timeout);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        addr_t a;
        void'($urandom(75));
        for (int i = 0; i < depth; i++) begin
            sram_shadow[i] = '0;
            sram_known[i]  = '0;
        end
        for (int r = 0; r < num_regs; r++) begin
            dev_shadow[r] = '0;
        end
        rst_i             = 1'b1;
        fetch_req_valid_i = 1'b0;
        fetch_req_i       = '0;
        fetch_rsp_ready_i = 1'b1;
        data_req_valid_i  = 1'b0;
        data_req_i        = '0;
        data_rsp_ready_i  = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // sram writes, strobe merge and aliasing at the window edges
        a = `MEM_BASE + 32'h128;
        send_data(`MEM_LIMIT, 1'b1, 64'h0123_4567_89ab_cdef, 8'hff);
        send_data(`MEM_BASE, 1'b0, '0, '0);
        send_data(a, 1'b1, {$urandom, $urandom}, 8'hff);
        send_data(a, 1'b1, {$urandom, $urandom}, 8'h3c);
        send_data(a, 1'b0, '0, '0);
        send_data(a + 32'h1000, 1'b1, {$urandom, $urandom}, 8'hc1);
        send_data(a, 1'b0, '0, '0);
        for (int i = 0; i < 32; i++) begin
            a = `MEM_BASE | (1 << half_bit) | (i << 3);
            send_data(a, 1'b1, {$urandom, $urandom}, 8'hff);
        end
        // fill the lower half so random data reads have known words
        for (int i = 0; i < depth / 2; i++) begin
            send_data(`MEM_BASE | (i << 3), 1'b1, {$urandom, $urandom}, 8'hff);
        end
        wait_drained();

        // device registers read zero, then merge strobed writes
        for (int r = 0; r < num_regs; r++) begin
            send_data(32'h1000_0000 + (r << 3), 1'b0, '0, '0);
        end
        for (int r = 0; r < num_regs; r++) begin
            send_data(32'h9000_0000 + (r << 3), 1'b1, {$urandom, $urandom}, strb_t'($urandom));
        end
        for (int r = 0; r < num_regs; r++) begin
            send_data(32'h0000_0020 + (r << 3), 1'b0, '0, '0);
        end
        wait_drained();

        // fetches in the window and both sides outside it
        for (int i = 0; i < 8; i++) begin
            send_fetch(`MEM_BASE | (1 << half_bit) | (i << 3));
        end
        send_fetch(`MEM_BASE - 1);
        send_fetch(`MEM_LIMIT + 1);
        wait_drained();

        fork
            run_data_traffic(n_rand);
            run_fetch_traffic(n_rand);
        join
        wait_drained();

        // response back-pressure fills the slots
        rdy_pct   = 40;
        stall_cnt = 0;
        fork
            run_data_traffic(n_rand);
            run_fetch_traffic(n_rand);
        join
        wait_drained();
        if (stall_cnt == 0) begin
            other_errs++;
            $display("error: request ready never dropped under response back-pressure");
        end

        $display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
        if (mismatch_errs + other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/mem_subsys_top.sv ====
`include "mem_cfg_cfg.svh"

module mem_subsys_top import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    // fetch port
    input  logic       fetch_req_valid_i,
    output logic       fetch_req_ready_o,
    input  fetch_req_t fetch_req_i,
    output logic       fetch_rsp_valid_o,
    input  logic       fetch_rsp_ready_i,
    output mem_rsp_t   fetch_rsp_o,
    // data port
    input  logic       data_req_valid_i,
    output logic       data_req_ready_o,
    input  data_req_t  data_req_i,
    output logic       data_rsp_valid_o,
    input  logic       data_rsp_ready_i,
    output mem_rsp_t   data_rsp_o
);

    // slot to arbiter
    logic       fetch_slot_valid;
    logic       fetch_slot_ready;
    fetch_req_t fetch_slot_req;
    logic       data_slot_valid;
    logic       data_slot_ready;
    data_req_t  data_slot_req;

    logic timer_start;
    logic timer_done;

    // arbiter to sram
    logic                       sram_en;
    logic                       sram_we;
    logic [`MEM_DEPTH_LOG2-1:0] sram_index;
    data_t                      sram_wdata;
    strb_t                      sram_strb;
    data_t                      sram_rdata;

    // arbiter to device registers
    logic                      dev_en;
    logic                      dev_we;
    logic [`DEV_REGS_LOG2-1:0] dev_index;
    data_t                     dev_wdata;
    strb_t                     dev_strb;
    data_t                     dev_rdata;

    //**********************************************************
    // request slots
    //**********************************************************
    req_slot #(
        .payload_t ( fetch_req_t )
    ) i_fetch_slot (
        .clk         ( clk               ),
        .rst_i       ( rst_i             ),
        .in_valid_i  ( fetch_req_valid_i ),
        .in_ready_o  ( fetch_req_ready_o ),
        .in_data_i   ( fetch_req_i       ),
        .out_valid_o ( fetch_slot_valid  ),
        .out_ready_i ( fetch_slot_ready  ),
        .out_data_o  ( fetch_slot_req    )
    );

    req_slot #(
        .payload_t ( data_req_t )
    ) i_data_slot (
        .clk         ( clk              ),
        .rst_i       ( rst_i            ),
        .in_valid_i  ( data_req_valid_i ),
        .in_ready_o  ( data_req_ready_o ),
        .in_data_i   ( data_req_i       ),
        .out_valid_o ( data_slot_valid  ),
        .out_ready_i ( data_slot_ready  ),
        .out_data_o  ( data_slot_req    )
    );

    //**********************************************************
    // arbiter and its targets
    //**********************************************************
    bus_arbiter_fsm i_bus_arbiter_fsm (
        .clk               ( clk               ),
        .rst_i             ( rst_i             ),
        .fetch_valid_i     ( fetch_slot_valid  ),
        .fetch_ready_o     ( fetch_slot_ready  ),
        .fetch_req_i       ( fetch_slot_req    ),
        .data_valid_i      ( data_slot_valid   ),
        .data_ready_o      ( data_slot_ready   ),
        .data_req_i        ( data_slot_req     ),
        .timer_start_o     ( timer_start       ),
        .timer_done_i      ( timer_done        ),
        .sram_en_o         ( sram_en           ),
        .sram_we_o         ( sram_we           ),
        .sram_index_o      ( sram_index        ),
        .sram_wdata_o      ( sram_wdata        ),
        .sram_strb_o       ( sram_strb         ),
        .sram_rdata_i      ( sram_rdata        ),
        .dev_en_o          ( dev_en            ),
        .dev_we_o          ( dev_we            ),
        .dev_index_o       ( dev_index         ),
        .dev_wdata_o       ( dev_wdata         ),
        .dev_strb_o        ( dev_strb          ),
        .dev_rdata_i       ( dev_rdata         ),
        .fetch_rsp_valid_o ( fetch_rsp_valid_o ),
        .fetch_rsp_ready_i ( fetch_rsp_ready_i ),
        .fetch_rsp_o       ( fetch_rsp_o       ),
        .data_rsp_valid_o  ( data_rsp_valid_o  ),
        .data_rsp_ready_i  ( data_rsp_ready_i  ),
        .data_rsp_o        ( data_rsp_o        )
    );

    sram_wait_timer i_sram_wait_timer (
        .clk     ( clk         ),
        .rst_i   ( rst_i       ),
        .start_i ( timer_start ),
        .done_o  ( timer_done  )
    );

    sram_store i_sram_store (
        .clk     ( clk        ),
        .en_i    ( sram_en    ),
        .we_i    ( sram_we    ),
        .index_i ( sram_index ),
        .wdata_i ( sram_wdata ),
        .strb_i  ( sram_strb  ),
        .rdata_o ( sram_rdata )
    );

    mmio_regs i_mmio_regs (
        .clk     ( clk       ),
        .rst_i   ( rst_i     ),
        .en_i    ( dev_en    ),
        .we_i    ( dev_we    ),
        .index_i ( dev_index ),
        .wdata_i ( dev_wdata ),
        .strb_i  ( dev_strb  ),
        .rdata_o ( dev_rdata )
    );

endmodule

// ==== rtl/mmio_regs.sv ====
`include "mem_cfg_cfg.svh"

module mmio_regs import mem_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      en_i,
    input  logic                      we_i,
    input  logic [`DEV_REGS_LOG2-1:0] index_i,
    input  data_t                     wdata_i,
    input  strb_t                     strb_i,
    output data_t                     rdata_o
);

    localparam int num_regs = 2 ** `DEV_REGS_LOG2;

    data_t regs_q [num_regs];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int r = 0; r < num_regs; r++) begin
                regs_q[r] <= '0;
            end
        end else if (en_i && we_i) begin
            for (int b = 0; b < `MEM_STRB_W; b++) begin
                if (strb_i[b]) begin
                    regs_q[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // read is combinational within the access cycle
    assign rdata_o = regs_q[index_i];

endmodule

// ==== rtl/sram_store.sv ====
`include "mem_cfg_cfg.svh"

module sram_store import mem_pkg::*; (
    input  logic                       clk,
    input  logic                       en_i,
    input  logic                       we_i,
    input  logic [`MEM_DEPTH_LOG2-1:0] index_i,
    input  data_t                      wdata_i,
    input  strb_t                      strb_i,
    output data_t                      rdata_o
);

    localparam int depth = 2 ** `MEM_DEPTH_LOG2;

    data_t mem_q [depth];

    // byte lanes written under strobe
    always_ff @(posedge clk) begin
        if (en_i && we_i) begin
            for (int b = 0; b < `MEM_STRB_W; b++) begin
                if (strb_i[b]) begin
                    mem_q[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // registered read returns old contents on a write
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_o <= mem_q[index_i];
        end
    end

endmodule

// ==== rtl/sram_wait_timer.sv ====
`include "mem_cfg_cfg.svh"

module sram_wait_timer import mem_pkg::*; (
    input  logic clk,
    input  logic rst_i,
    input  logic start_i,
    output logic done_o
);

    wait_cnt_t cnt_q;

    // zero means idle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (start_i) begin
            cnt_q <= wait_cnt_t'(`SRAM_WAIT);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // last count is the done cycle
    assign done_o = (cnt_q == wait_cnt_t'(1));

    // arbiter must not restart a running wait
    a_no_restart: assert property (@(posedge clk) disable iff (rst_i)
        start_i |-> (cnt_q == '0));

endmodule

// ==== rtl/bus_arbiter_fsm.sv ====
`include "mem_cfg_cfg.svh"

module bus_arbiter_fsm import mem_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_i,
    // fetch slot
    input  logic                       fetch_valid_i,
    output logic                       fetch_ready_o,
    input  fetch_req_t                 fetch_req_i,
    // data slot
    input  logic                       data_valid_i,
    output logic                       data_ready_o,
    input  data_req_t                  data_req_i,
    // wait timer
    output logic                       timer_start_o,
    input  logic                       timer_done_i,
    // sram
    output logic                       sram_en_o,
    output logic                       sram_we_o,
    output logic [`MEM_DEPTH_LOG2-1:0] sram_index_o,
    output data_t                      sram_wdata_o,
    output strb_t                      sram_strb_o,
    input  data_t                      sram_rdata_i,
    // device registers
    output logic                       dev_en_o,
    output logic                       dev_we_o,
    output logic [`DEV_REGS_LOG2-1:0]  dev_index_o,
    output data_t                      dev_wdata_o,
    output strb_t                      dev_strb_o,
    input  data_t                      dev_rdata_i,
    // responses
    output logic                       fetch_rsp_valid_o,
    input  logic                       fetch_rsp_ready_i,
    output mem_rsp_t                   fetch_rsp_o,
    output logic                       data_rsp_valid_o,
    input  logic                       data_rsp_ready_i,
    output mem_rsp_t                   data_rsp_o
);

    localparam int offset_w = $clog2(`MEM_STRB_W);

    arb_state_t state_q;
    arb_state_t state_d;
    grant_t     last_grant_q;
    addr_t      cur_addr_q;
    logic       cur_we_q;
    data_t      cur_wdata_q;
    strb_t      cur_strb_q;
    data_t      rsp_data_q;
    resp_t      rsp_code_q;
    logic       take_fetch;
    logic       take_data;
    addr_t      sel_addr;
    logic       sel_in_window;

    //**********************************************************
    // request pick and address decode
    //**********************************************************
    // on a tie the requester not served last goes first
    assign take_fetch = (state_q == arb_idle) && fetch_valid_i &&
                        (!data_valid_i || last_grant_q == grant_data);
    assign take_data  = (state_q == arb_idle) && data_valid_i && !take_fetch;

    assign fetch_ready_o = take_fetch;
    assign data_ready_o  = take_data;

    assign sel_addr      = take_data ? data_req_i.addr : fetch_req_i.addr;
    assign sel_in_window = (sel_addr >= `MEM_BASE) && (sel_addr <= `MEM_LIMIT);

    assign timer_start_o = (take_fetch || take_data) && sel_in_window;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            arb_idle: begin
                if (take_fetch || take_data) begin
                    if (sel_in_window) begin
                        state_d = arb_sram_wait;
                    end else if (take_data) begin
                        state_d = arb_dev_access;
                    end else begin
                        state_d = arb_respond;
                    end
                end
            end
            arb_sram_wait: begin
                // writes have nothing to read back
                if (timer_done_i) begin
                    state_d = cur_we_q ? arb_respond : arb_sram_read;
                end
            end
            arb_sram_read:  state_d = arb_respond;
            arb_dev_access: state_d = arb_respond;
            arb_respond: begin
                if ((fetch_rsp_valid_o && fetch_rsp_ready_i) ||
                    (data_rsp_valid_o && data_rsp_ready_i)) begin
                    state_d = arb_idle;
                end
            end
            default: state_d = arb_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= arb_idle;
            last_grant_q <= grant_data;
        end else begin
            state_q <= state_d;
            if (take_fetch) begin
                last_grant_q <= grant_fetch;
            end else if (take_data) begin
                last_grant_q <= grant_data;
            end
        end
    end

    // captured request
    always_ff @(posedge clk) begin
        if (take_fetch) begin
            cur_addr_q  <= fetch_req_i.addr;
            cur_we_q    <= 1'b0;
            cur_wdata_q <= '0;
            cur_strb_q  <= '0;
        end else if (take_data) begin
            cur_addr_q  <= data_req_i.addr;
            cur_we_q    <= data_req_i.we;
            cur_wdata_q <= data_req_i.wdata;
            cur_strb_q  <= data_req_i.strb;
        end
    end

    //**********************************************************
    // sram and device register access
    //**********************************************************
    assign sram_en_o    = (state_q == arb_sram_wait) && timer_done_i;
    assign sram_we_o    = cur_we_q;
    assign sram_index_o = cur_addr_q[offset_w +: `MEM_DEPTH_LOG2];
    assign sram_wdata_o = cur_wdata_q;
    assign sram_strb_o  = cur_strb_q;

    assign dev_en_o    = (state_q == arb_dev_access);
    assign dev_we_o    = cur_we_q;
    assign dev_index_o = cur_addr_q[offset_w +: `DEV_REGS_LOG2];
    assign dev_wdata_o = cur_wdata_q;
    assign dev_strb_o  = cur_strb_q;

    //**********************************************************
    // response build
    //**********************************************************
    // zero data unless a read fills it in
    always_ff @(posedge clk) begin
        if (take_fetch || take_data) begin
            rsp_data_q <= '0;
            rsp_code_q <= (take_fetch && !sel_in_window) ? resp_decerr : resp_okay;
        end else if (state_q == arb_sram_read) begin
            rsp_data_q <= sram_rdata_i;
        end else if (state_q == arb_dev_access && !cur_we_q) begin
            rsp_data_q <= dev_rdata_i;
        end
    end

    assign fetch_rsp_valid_o = (state_q == arb_respond) && (last_grant_q == grant_fetch);
    assign data_rsp_valid_o  = (state_q == arb_respond) && (last_grant_q == grant_data);

    assign fetch_rsp_o.rdata = rsp_data_q;
    assign fetch_rsp_o.resp  = rsp_code_q;
    assign data_rsp_o.rdata  = rsp_data_q;
    assign data_rsp_o.resp   = rsp_code_q;

    a_one_rsp: assert property (@(posedge clk) disable iff (rst_i)
        !(fetch_rsp_valid_o && data_rsp_valid_o));

    a_fetch_rsp_hold: assert property (@(posedge clk) disable iff (rst_i)
        fetch_rsp_valid_o && !fetch_rsp_ready_i |=>
            fetch_rsp_valid_o && $stable(fetch_rsp_o));

    a_data_rsp_hold: assert property (@(posedge clk) disable iff (rst_i)
        data_rsp_valid_o && !data_rsp_ready_i |=>
            data_rsp_valid_o && $stable(data_rsp_o));

endmodule

// ==== rtl/req_slot.sv ====
module req_slot import mem_pkg::*; #(
    parameter type payload_t = fetch_req_t
) (
    input  logic     clk,
    input  logic     rst_i,
    // requester side
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    // arbiter side
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // free when empty or when the held entry leaves this cycle
    assign in_ready_o  = !valid_q || out_ready_i;
    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    // payload held steady toward the arbiter until popped
    a_hold_payload: assert property (@(posedge clk) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

// ==== rtl/mem_pkg.sv ====
`include "mem_cfg_cfg.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0] addr_t;
    typedef logic [`MEM_DATA_W-1:0] data_t;
    typedef logic [`MEM_STRB_W-1:0] strb_t;

    // same encoding as the axi resp field
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_decerr = 2'b11
    } resp_t;

    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        addr_t addr;
        logic  we;
        data_t wdata;
        strb_t strb;
    } data_req_t;

    typedef struct packed {
        data_t rdata;
        resp_t resp;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        arb_idle,
        arb_sram_wait,
        arb_sram_read,
        arb_dev_access,
        arb_respond
    } arb_state_t;

    typedef enum logic {
        grant_fetch,
        grant_data
    } grant_t;

    // latency counter for the sram model
    typedef logic [$clog2(`SRAM_WAIT + 1)-1:0] wait_cnt_t;

endpackage

// ==== include/mem_cfg_cfg.svh ====
`ifndef MEM_CFG_CFG_SVH
`define MEM_CFG_CFG_SVH

// bus widths
`define MEM_ADDR_W      32
`define MEM_DATA_W      64
`define MEM_STRB_W      8

// main memory window with both ends inclusive
`define MEM_BASE        32'h8000_0000
`define MEM_LIMIT       32'h8800_0000

// sram word index bits
`define MEM_DEPTH_LOG2  8

// cycles from timer start to the sram access
`define SRAM_WAIT       3

// four 64-bit device registers
`define DEV_REGS_LOG2   2

`endif
